//--- src.f
verilog/addr_pkg.sv
verilog/thread_counter.sv
verilog/offset_table.sv
verilog/addr_translator.sv
verilog/offset_csr.sv
verilog/addr_unit.sv
dv/addr_unit_tb.sv

//--- run.sh
#!/bin/sh
# Builds the address translation testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps --top-module addr_unit_tb \
    -f src.f -o addr_unit_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/addr_unit_sim
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi

exit 0

//--- dv/addr_unit_tb.sv
// Directed testbench for the address translation stage. Drives the request
// stream and the AXI4-Lite port and scores every result.
`default_nettype none

module addr_unit_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import addr_pkg::*;

    localparam int TIMEOUT_CYCLES = 100;
    localparam int STREAM_LENGTH  = 200;

    typedef logic [AXI_ADDR_WIDTH-1:0] axi_addr_t;
    typedef logic [AXI_DATA_WIDTH-1:0] axi_data_t;

    localparam addr_t HIGHMEM_LAST = HIGHMEM_BASE + HIGHMEM_COUNT - 16'd1;
    localparam addr_t IO_LAST      = IO_BASE + IO_COUNT - 16'd1;

    // one expected result, tagged with the cycle its request entered.
    typedef struct packed {
        logic [31:0] cycle;
        thread_t     thread;
        logic        raw;
        addr_t       addr;
    } expect_t;

    logic                        clock;
    logic                        reset;
    addr_req_t                   req;
    addr_res_t                   res;
    axi_addr_t                   awaddr;
    logic                        awvalid;
    logic                        awready;
    axi_data_t                   wdata;
    logic [AXI_DATA_WIDTH/8-1:0] wstrb;
    logic                        wvalid;
    logic                        wready;
    logic [1:0]                  bresp;
    logic                        bvalid;
    logic                        bready;
    axi_addr_t                   araddr;
    logic                        arvalid;
    logic                        arready;
    axi_data_t                   rdata;
    logic [1:0]                  rresp;
    logic                        rvalid;
    logic                        rready;

    int          seed = 32'h61a2_631c;
    addr_t       model_offset [THREAD_COUNT];
    thread_t     model_thread;
    logic [31:0] cycle_count;
    expect_t     pending [$];

    addr_unit dut0 (.*);

    always #5 clock = ~clock;

    task automatic abort_run(input string message);
        $display("%s", message);
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            abort_run($sformatf("Error: %s is 0x%h, expected 0x%h", name, actual, expected));
        end
    endtask

    function automatic logic is_passthrough(input addr_t addr);
        logic in_highmem;
        logic in_io;
        in_highmem = (addr >= HIGHMEM_BASE) && (addr <= HIGHMEM_LAST);
        in_io      = (addr >= IO_BASE) && (addr <= IO_LAST);
        return in_highmem || in_io;
    endfunction

    function automatic axi_addr_t reg_address(input int thread);
        return OFFSET_REG_BASE + axi_addr_t'(4 * thread);
    endfunction

    // the scoreboard's thread model restarts with reset.
    always @(posedge clock) begin : scoreboard
        expect_t entry;
        if (reset) begin
            model_thread = '0;
            cycle_count  = '0;
            pending.delete();
        end else begin
            if (req.valid) begin
                entry.cycle  = cycle_count;
                entry.thread = model_thread;
                entry.raw    = is_passthrough(req.addr);
                entry.addr   = entry.raw ? req.addr : req.addr + model_offset[model_thread];
                pending.push_back(entry);
            end
            if (res.valid && pending.size() == 0) begin
                abort_run("a result appeared with no request in flight");
            end else if (res.valid) begin
                entry = pending.pop_front();
                check_value("result latency", cycle_count - entry.cycle, 32'd2);
                check_value("res.thread", 32'(res.thread), 32'(entry.thread));
                check_value("res.raw", 32'(res.raw), 32'(entry.raw));
                check_value("res.addr", 32'(res.addr), 32'(entry.addr));
            end
            if (pending.size() != 0 && cycle_count - pending[0].cycle > 32'd2) begin
                abort_run("an expected result did not appear on res");
            end
            model_thread = model_thread + 3'd1;
            cycle_count  = cycle_count + 32'd1;
        end
    end

    task automatic axi_write(input axi_addr_t addr, input axi_data_t data,
                             input int hold_cycles, output logic [1:0] resp);
        int waited;
        @(posedge clock);
        awaddr  <= addr;
        awvalid <= 1'b1;
        wdata   <= data;
        wstrb   <= '1;
        wvalid  <= 1'b1;
        bready  <= (hold_cycles == 0);
        waited = 0;
        do begin
            @(posedge clock);
            waited++;
            if (waited > TIMEOUT_CYCLES) begin
                abort_run("write address and data were never accepted");
            end
        end while (!(awready && wready));
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        waited = 0;
        do begin
            @(posedge clock);
            waited++;
            if (waited > TIMEOUT_CYCLES) begin
                abort_run("write response never arrived");
            end
        end while (!bvalid);
        resp = bresp;
        // response must hold while bready stays low.
        for (int i = 0; i < hold_cycles; i++) begin
            @(posedge clock);
            check_value("bvalid", 32'(bvalid), 32'd1);
            check_value("bresp", 32'(bresp), 32'(resp));
        end
        if (hold_cycles > 0) begin
            bready <= 1'b1;
            @(posedge clock);
            check_value("bvalid", 32'(bvalid), 32'd1);
        end
        bready <= 1'b0;
    endtask

    task automatic axi_read(input axi_addr_t addr, input int hold_cycles,
                            output axi_data_t data, output logic [1:0] resp);
        int waited;
        @(posedge clock);
        araddr  <= addr;
        arvalid <= 1'b1;
        rready  <= (hold_cycles == 0);
        waited = 0;
        do begin
            @(posedge clock);
            waited++;
            if (waited > TIMEOUT_CYCLES) begin
                abort_run("read address was never accepted");
            end
        end while (!arready);
        arvalid <= 1'b0;
        waited = 0;
        do begin
            @(posedge clock);
            waited++;
            if (waited > TIMEOUT_CYCLES) begin
                abort_run("read data never arrived");
            end
        end while (!rvalid);
        data = rdata;
        resp = rresp;
        for (int i = 0; i < hold_cycles; i++) begin
            @(posedge clock);
            check_value("rvalid", 32'(rvalid), 32'd1);
            check_value("rdata", rdata, data);
            check_value("rresp", 32'(rresp), 32'(resp));
        end
        if (hold_cycles > 0) begin
            rready <= 1'b1;
            @(posedge clock);
            check_value("rvalid", 32'(rvalid), 32'd1);
        end
        rready <= 1'b0;
    endtask

    task automatic send_address(input addr_t addr);
        @(posedge clock);
        req.valid <= 1'b1;
        req.addr  <= addr;
    endtask

    task automatic end_stream();
        int waited;
        @(posedge clock);
        req.valid <= 1'b0;
        @(posedge clock);
        waited = 0;
        while (pending.size() != 0) begin
            @(posedge clock);
            waited++;
            if (waited > TIMEOUT_CYCLES) begin
                abort_run("results did not drain from the pipeline");
            end
        end
    endtask

    task automatic check_all_offsets();
        axi_data_t  data;
        logic [1:0] resp;
        for (int t = 0; t < THREAD_COUNT; t++) begin
            axi_read(reg_address(t), 0, data, resp);
            check_value("rdata", data, {16'h0000, model_offset[t]});
            check_value("rresp", 32'(resp), 32'(RESP_OKAY));
        end
    endtask

    task automatic verify_reset_state();
        check_value("awready", 32'(awready), 32'd0);
        check_value("wready", 32'(wready), 32'd0);
        check_value("arready", 32'(arready), 32'd0);
        check_value("bvalid", 32'(bvalid), 32'd0);
        check_value("rvalid", 32'(rvalid), 32'd0);
        check_value("res.valid", 32'(res.valid), 32'd0);
        // any stray result while idle trips the scoreboard.
        repeat (10) @(posedge clock);
        check_all_offsets();
    endtask

    task automatic write_read_offsets();
        logic [1:0] resp;
        addr_t      value;
        for (int t = 0; t < THREAD_COUNT; t++) begin
            value = addr_t'(16'h2345 * (t + 1));
            axi_write(reg_address(t), {16'hC0DE, value}, 0, resp);
            check_value("bresp", 32'(resp), 32'(RESP_OKAY));
            model_offset[t] = value;
        end
        check_all_offsets();
    endtask

    task automatic stream_random_addresses(input int count);
        logic [31:0] draw;
        addr_t       addr;
        for (int n = 0; n < count; n++) begin
            draw = $random(seed);
            addr = draw[15:0];
            if (is_passthrough(addr)) begin
                addr[15] = 1'b0;
            end
            send_address(addr);
        end
        end_stream();
    endtask

    task automatic translate_window_edges();
        addr_t edges [7] = '{16'hE000, 16'hEFFF, 16'hFF00, 16'hFFFF,
                             16'hDFFF, 16'hF000, 16'hFEFF};
        for (int i = 0; i < 7; i++) begin
            send_address(edges[i]);
        end
        end_stream();
    endtask

    task automatic reject_bad_addresses();
        axi_data_t  data;
        logic [1:0] resp;
        axi_write(8'h20, 32'hFFFF_FFFF, 0, resp);
        check_value("bresp", 32'(resp), 32'(RESP_SLVERR));
        axi_write(8'h05, 32'h0000_1111, 0, resp);
        check_value("bresp", 32'(resp), 32'(RESP_SLVERR));
        axi_read(8'h40, 0, data, resp);
        check_value("rresp", 32'(resp), 32'(RESP_SLVERR));
        check_value("rdata", data, 32'd0);
        axi_read(8'h06, 0, data, resp);
        check_value("rresp", 32'(resp), 32'(RESP_SLVERR));
        check_value("rdata", data, 32'd0);
        check_all_offsets();
    endtask

    task automatic hold_responses();
        axi_data_t  data;
        logic [1:0] resp;
        axi_write(reg_address(3), 32'h1234_7E01, 4, resp);
        check_value("bresp", 32'(resp), 32'(RESP_OKAY));
        model_offset[3] = 16'h7E01;
        axi_read(reg_address(3), 4, data, resp);
        check_value("rresp", 32'(resp), 32'(RESP_OKAY));
        check_value("rdata", data, 32'h0000_7E01);
        stream_random_addresses(16);
    endtask

    initial begin
        clock   = 1'b0;
        reset   = 1'b1;
        req     = '0;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        for (int t = 0; t < THREAD_COUNT; t++) begin
            model_offset[t] = '0;
        end
        repeat (5) @(posedge clock);
        reset <= 1'b0;
        verify_reset_state();
        write_read_offsets();
        stream_random_addresses(STREAM_LENGTH);
        translate_window_edges();
        reject_bad_addresses();
        hold_responses();
        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/addr_unit.sv
// Address translation stage top. Thread counter, offset table, translator
// and the AXI4-Lite offset register block.
`default_nettype none

module addr_unit (
    input  logic                                  clock,
    input  logic                                  reset,
    input  addr_pkg::addr_req_t                   req,
    output addr_pkg::addr_res_t                   res,
    input  logic [addr_pkg::AXI_ADDR_WIDTH-1:0]   awaddr,
    input  logic                                  awvalid,
    output logic                                  awready,
    input  logic [addr_pkg::AXI_DATA_WIDTH-1:0]   wdata,
    input  logic [addr_pkg::AXI_DATA_WIDTH/8-1:0] wstrb,
    input  logic                                  wvalid,
    output logic                                  wready,
    output logic [1:0]                            bresp,
    output logic                                  bvalid,
    input  logic                                  bready,
    input  logic [addr_pkg::AXI_ADDR_WIDTH-1:0]   araddr,
    input  logic                                  arvalid,
    output logic                                  arready,
    output logic [addr_pkg::AXI_DATA_WIDTH-1:0]   rdata,
    output logic [1:0]                            rresp,
    output logic                                  rvalid,
    input  logic                                  rready
);
    import addr_pkg::*;

    thread_t current_thread;
    thread_t next_thread;
    addr_t   offset;
    logic    write_enable;
    thread_t write_thread;
    addr_t   write_offset;
    thread_t host_thread;
    addr_t   host_offset;

    thread_counter counter0 (
        .clock          (clock),
        .reset          (reset),
        .current_thread (current_thread),
        .next_thread    (next_thread)
    );

    offset_table table0 (
        .clock        (clock),
        .reset        (reset),
        .write_enable (write_enable),
        .write_thread (write_thread),
        .write_offset (write_offset),
        .next_thread  (next_thread),
        .offset       (offset),
        .host_thread  (host_thread),
        .host_offset  (host_offset)
    );

    addr_translator translator0 (
        .clock          (clock),
        .reset          (reset),
        .current_thread (current_thread),
        .offset         (offset),
        .req            (req),
        .res            (res)
    );

    offset_csr csr0 (
        .clock        (clock),
        .reset        (reset),
        .awaddr       (awaddr),
        .awvalid      (awvalid),
        .awready      (awready),
        .wdata        (wdata),
        .wstrb        (wstrb),
        .wvalid       (wvalid),
        .wready       (wready),
        .bresp        (bresp),
        .bvalid       (bvalid),
        .bready       (bready),
        .araddr       (araddr),
        .arvalid      (arvalid),
        .arready      (arready),
        .rdata        (rdata),
        .rresp        (rresp),
        .rvalid       (rvalid),
        .rready       (rready),
        .write_enable (write_enable),
        .write_thread (write_thread),
        .write_offset (write_offset),
        .host_thread  (host_thread),
        .host_offset  (host_offset)
    );

endmodule

`default_nettype wire

//--- verilog/offset_csr.sv
// AXI4-Lite slave exposing the eight per-thread offset registers.
`default_nettype none

module offset_csr (
    input  logic                                  clock,
    input  logic                                  reset,
    input  logic [addr_pkg::AXI_ADDR_WIDTH-1:0]   awaddr,
    input  logic                                  awvalid,
    output logic                                  awready,
    input  logic [addr_pkg::AXI_DATA_WIDTH-1:0]   wdata,
    input  logic [addr_pkg::AXI_DATA_WIDTH/8-1:0] wstrb,
    input  logic                                  wvalid,
    output logic                                  wready,
    output logic [1:0]                            bresp,
    output logic                                  bvalid,
    input  logic                                  bready,
    input  logic [addr_pkg::AXI_ADDR_WIDTH-1:0]   araddr,
    input  logic                                  arvalid,
    output logic                                  arready,
    output logic [addr_pkg::AXI_DATA_WIDTH-1:0]   rdata,
    output logic [1:0]                            rresp,
    output logic                                  rvalid,
    input  logic                                  rready,
    output logic                                  write_enable,
    output addr_pkg::thread_t                     write_thread,
    output addr_pkg::addr_t                       write_offset,
    output addr_pkg::thread_t                     host_thread,
    input  addr_pkg::addr_t                       host_offset
);
    import addr_pkg::*;

    typedef logic [AXI_ADDR_WIDTH-1:0] axi_addr_t;

    // word aligned and inside the eight registers.
    function automatic logic reg_hit(input axi_addr_t addr);
        axi_addr_t rel;
        rel = addr - OFFSET_REG_BASE;
        return (rel[1:0] == 2'b00) && (rel < axi_addr_t'(THREAD_COUNT * 4));
    endfunction

    function automatic thread_t reg_index(input axi_addr_t addr);
        axi_addr_t rel;
        rel = addr - OFFSET_REG_BASE;
        return rel[THREAD_WIDTH+1:2];
    endfunction

    logic write_ready;
    logic write_fire;
    logic write_hit;
    logic read_ready;
    logic read_fire;
    logic read_hit;

    // write channel. wstrb is taken as full word.
    assign awready      = write_ready;
    assign wready       = write_ready;
    assign write_fire   = write_ready && awvalid && wvalid;
    assign write_hit    = reg_hit(awaddr);
    assign write_enable = write_fire && write_hit;
    assign write_thread = reg_index(awaddr);
    assign write_offset = wdata[ADDR_WIDTH-1:0];

    always_ff @(posedge clock) begin
        if (reset) begin
            write_ready <= 1'b0;
            bvalid      <= 1'b0;
        end else begin
            // AW and W taken together, never with a response still pending.
            write_ready <= !write_ready && !bvalid && awvalid && wvalid;
            if (write_fire) begin
                bvalid <= 1'b1;
            end else if (bvalid && bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (write_fire) begin
            bresp <= write_hit ? RESP_OKAY : RESP_SLVERR;
        end
    end

    // read channel.
    assign arready     = read_ready;
    assign read_fire   = read_ready && arvalid;
    assign read_hit    = reg_hit(araddr);
    assign host_thread = reg_index(araddr);

    always_ff @(posedge clock) begin
        if (reset) begin
            read_ready <= 1'b0;
            rvalid     <= 1'b0;
        end else begin
            read_ready <= !read_ready && !rvalid && arvalid;
            if (read_fire) begin
                rvalid <= 1'b1;
            end else if (rvalid && rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (read_fire) begin
            if (read_hit) begin
                rdata <= {{(AXI_DATA_WIDTH - ADDR_WIDTH){1'b0}}, host_offset};
                rresp <= RESP_OKAY;
            end else begin
                rdata <= '0;
                rresp <= RESP_SLVERR;
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/addr_translator.sv
// Two-stage address translator. Adds the current thread's offset unless the
// address falls in the high-memory or I/O window.
`default_nettype none

module addr_translator (
    input  logic                clock,
    input  logic                reset,
    input  addr_pkg::thread_t   current_thread,
    input  addr_pkg::addr_t     offset,
    input  addr_pkg::addr_req_t req,
    output addr_pkg::addr_res_t res
);
    import addr_pkg::*;

    function automatic logic in_window(input addr_t addr, input addr_t base,
                                       input addr_t count);
        addr_t rel;
        rel = addr - base;
        return (addr >= base) && (rel < count);
    endfunction

    logic    in_highmem;
    logic    in_io;

    logic    s1_valid;
    thread_t s1_thread;
    addr_t   s1_raw_addr;
    addr_t   s1_offset_addr;
    logic    s1_use_raw;

    logic    s2_valid;
    thread_t s2_thread;
    logic    s2_raw;
    addr_t   s2_addr;

    assign in_highmem = in_window(req.addr, HIGHMEM_BASE, HIGHMEM_COUNT);
    assign in_io      = in_window(req.addr, IO_BASE, IO_COUNT);

    // stage 1.
    always_ff @(posedge clock) begin
        if (reset) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= req.valid;
        end
    end

    always_ff @(posedge clock) begin
        s1_thread      <= current_thread;
        s1_raw_addr    <= req.addr;
        s1_offset_addr <= req.addr + offset;
        s1_use_raw     <= in_highmem || in_io;
    end

    // stage 2 picks raw or translated.
    always_ff @(posedge clock) begin
        if (reset) begin
            s2_valid <= 1'b0;
        end else begin
            s2_valid <= s1_valid;
        end
    end

    always_ff @(posedge clock) begin
        s2_thread <= s1_thread;
        s2_raw    <= s1_use_raw;
        s2_addr   <= s1_use_raw ? s1_raw_addr : s1_offset_addr;
    end

    assign res = '{valid: s2_valid, thread: s2_thread, raw: s2_raw, addr: s2_addr};

endmodule

`default_nettype wire

//--- verilog/offset_table.sv
// Per-thread offset registers with a registered look-ahead read for the
// translator and a combinational read for host readback.
`default_nettype none

module offset_table (
    input  logic              clock,
    input  logic              reset,
    input  logic              write_enable,
    input  addr_pkg::thread_t write_thread,
    input  addr_pkg::addr_t   write_offset,
    input  addr_pkg::thread_t next_thread,
    output addr_pkg::addr_t   offset,
    input  addr_pkg::thread_t host_thread,
    output addr_pkg::addr_t   host_offset
);
    import addr_pkg::*;

    addr_t offsets [THREAD_COUNT];

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < THREAD_COUNT; i++) begin
                offsets[i] <= '0;
            end
        end else if (write_enable) begin
            offsets[write_thread] <= write_offset;
        end
    end

    // read for next_thread so the value is ready when it becomes current.
    // a write lands here one cycle later, hence the 2 cycle apply delay.
    always_ff @(posedge clock) begin
        if (reset) begin
            offset <= '0;
        end else begin
            offset <= offsets[next_thread];
        end
    end

    assign host_offset = offsets[host_thread];

endmodule

`default_nettype wire

//--- verilog/thread_counter.sv
// Round-robin thread counter for the barrel scheduler, one thread per cycle.
`default_nettype none

module thread_counter (
    input  logic              clock,
    input  logic              reset,
    output addr_pkg::thread_t current_thread,
    output addr_pkg::thread_t next_thread
);
    import addr_pkg::*;

    localparam thread_t LAST_THREAD = thread_t'(THREAD_COUNT - 1);

    // the table looks one thread ahead.
    always_comb begin
        if (current_thread == LAST_THREAD) begin
            next_thread = '0;
        end else begin
            next_thread = current_thread + thread_t'(1);
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            current_thread <= '0;
        end else begin
            current_thread <= next_thread;
        end
    end

endmodule

`default_nettype wire

//--- verilog/addr_pkg.sv
// Shared widths, address windows, register map and bus types for the
// per-thread address translation stage.
`default_nettype none

package addr_pkg;

    localparam int ADDR_WIDTH   = 16;
    localparam int THREAD_COUNT = 8;
    localparam int THREAD_WIDTH = 3;

    typedef logic [ADDR_WIDTH-1:0]   addr_t;
    typedef logic [THREAD_WIDTH-1:0] thread_t;

    // high-memory and I/O windows, never overlapping.
    localparam addr_t HIGHMEM_BASE  = 16'hE000;
    localparam addr_t HIGHMEM_COUNT = 16'h1000;
    localparam addr_t IO_BASE       = 16'hFF00;
    localparam addr_t IO_COUNT      = 16'h0100;

    localparam int AXI_ADDR_WIDTH = 8;
    localparam int AXI_DATA_WIDTH = 32;

    // thread n offset sits at base + 4n.
    localparam logic [AXI_ADDR_WIDTH-1:0] OFFSET_REG_BASE = 8'h00;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    typedef struct packed {
        logic  valid;
        addr_t addr;
    } addr_req_t;

    typedef struct packed {
        logic    valid;
        thread_t thread;
        logic    raw;
        addr_t   addr;
    } addr_res_t;

endpackage

`default_nettype wire
